//--- hw/axis_mux_pkg.sv
// Shared stream widths, channel count and beat format; imported by every mux source file
package axis_mux_pkg;

   // --------------------
   // Channel count
   // --------------------

   // Inputs merged onto the single output
   localparam int NUM_CH = 4;

   // Channel index width
   localparam int SEL_WIDTH = $clog2(NUM_CH);

   // --------------------
   // Beat widths
   // --------------------

   // Payload width in bits
   localparam int TDATA_WIDTH = 32;

   // One byte enable per data byte
   localparam int TKEEP_WIDTH = TDATA_WIDTH / 8;

   // User sideband, passed through untouched
   localparam int TUSER_WIDTH = 8;

   // --------------------
   // Beat format
   // --------------------

   // One beat as stored in the skid buffers and the output register
   // Field order sets the packed layout, data in the top bits
   typedef struct packed {
      logic [TDATA_WIDTH-1:0] data;
      logic [TKEEP_WIDTH-1:0] keep;
      logic                   last;
      logic [TUSER_WIDTH-1:0] user;
   } axis_beat_t;

endpackage

//--- hw/axis_stream_if.sv
// AXI-Stream valid/ready link carrying one beat; source side drives valid and beat
`timescale 1ns/1ps

interface axis_stream_if;
   import axis_mux_pkg::*;

   // Handshake pair
   // Transfer on a rising edge with both high
   logic valid;
   logic ready;

   // Beat content, held steady by the source until transfer
   axis_beat_t beat;

   // --------------------
   // Views
   // --------------------

   // Producer side
   modport source (
      output valid,
      output beat,
      input  ready
   );

   // Consumer side
   modport sink (
      input  valid,
      input  beat,
      output ready
   );

endinterface

//--- hw/axis_skid_buffer.sv
// Two-entry registered stream stage placed before each mux input with ready driven from a flop
`timescale 1ns/1ps

module axis_skid_buffer (
   input  logic         clk,
   input  logic         rst_n,
   axis_stream_if.sink   sink,
   axis_stream_if.source source
);
   import axis_mux_pkg::*;

   // Head entry, presented on source
   axis_beat_t main_beat;
   logic       main_valid;

   // Overflow entry, filled only while the head is stalled
   axis_beat_t skid_beat;
   logic       skid_valid;

   // Handshake strobes
   logic push;
   logic pop;

   // --------------------
   // Handshakes
   // --------------------

   // Upstream may push while the overflow slot is empty
   // Skid flag is a flop so no combinational path from source.ready
   assign sink.ready = !skid_valid;

   assign push = sink.valid && !skid_valid;
   assign pop  = main_valid && source.ready;

   assign source.valid = main_valid;
   assign source.beat  = main_beat;

   // --------------------
   // Storage
   // --------------------

   always_ff @(posedge clk) begin
      if (pop || !main_valid) begin
         // Head frees this cycle so refill from overflow first to keep order
         if (skid_valid) begin
            main_beat  <= skid_beat;
            main_valid <= 1'b1;
            skid_valid <= 1'b0;
         end else begin
            // Straight through when nothing is parked
            if (push) begin
               main_beat <= sink.beat;
            end
            main_valid <= push;
         end
      end else begin
         // Park the incoming beat while the head is stalled
         if (push) begin
            skid_beat  <= sink.beat;
            skid_valid <= 1'b1;
         end
      end

      // Both entries empty after reset
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end
   end

endmodule

//--- hw/fair_arbiter.sv
// Round-robin arbiter with packet hold; combinational grant, registered rotation pointer
`timescale 1ns/1ps

module fair_arbiter #(
   parameter  int NUM_INPUTS = 4,
   localparam int SEL_W      = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NUM_INPUTS-1:0] in_valid,
   input  logic [NUM_INPUTS-1:0] hold_priority,
   output logic [SEL_W-1:0]      out_select,
   output logic [NUM_INPUTS-1:0] out_select_1hot,
   output logic                  out_valid
);

   // First channel searched, one past the last winner
   logic [SEL_W-1:0] ptr;

   // Bids left after the hold filter
   logic [NUM_INPUTS-1:0] eligible;
   logic                  hold_active;

   // Search result
   logic [SEL_W-1:0] winner;
   logic             found;

   // --------------------
   // Hold filter
   // --------------------

   // A channel in mid-packet locks out everyone else
   assign hold_active = |hold_priority;
   assign eligible    = hold_active ? (in_valid & hold_priority) : in_valid;

   // --------------------
   // Rotating search
   // --------------------

   always_comb begin
      int idx;
      winner = '0;
      found  = 1'b0;
      for (int i = 0; i < NUM_INPUTS; i++) begin
         // Wrap around the channel range
         idx = int'(ptr) + i;
         if (idx >= NUM_INPUTS) begin
            idx = idx - NUM_INPUTS;
         end
         if (!found && eligible[idx]) begin
            found  = 1'b1;
            winner = SEL_W'(idx);
         end
      end
   end

   always_comb begin
      out_select_1hot = '0;
      if (found) begin
         out_select_1hot[winner] = 1'b1;
      end
   end

   assign out_select = winner;
   assign out_valid  = found;

   // Advance only on a fresh grant, held packets leave the order alone
   always_ff @(posedge clk) begin
      if (found && !hold_active) begin
         ptr <= (winner == SEL_W'(NUM_INPUTS - 1)) ? '0 : winner + 1'b1;
      end
      if (!rst_n) begin
         ptr <= '0;
      end
   end

endmodule

//--- hw/axis_packet_mux.sv
// Packet-level stream mux; skid buffer per input, round-robin choice, registered output
`timescale 1ns/1ps

module axis_packet_mux #(
   parameter int NUM_CH = axis_mux_pkg::NUM_CH
) (
   input  logic         clk,
   input  logic         rst_n,
   axis_stream_if.sink   sink [NUM_CH],
   axis_stream_if.source source
);
   import axis_mux_pkg::*;

   localparam int SEL_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

   // Arbiter result
   logic [SEL_W-1:0]  sel;
   logic [NUM_CH-1:0] sel_1hot;
   logic              sel_valid;

   // One bit per channel that has started but not finished a packet
   logic [NUM_CH-1:0] hold_1hot;
   logic              hold_any;

   // Buffered inputs, flattened for indexing
   logic [NUM_CH-1:0] in_valid;
   axis_beat_t        in_beat [NUM_CH];
   logic [NUM_CH-1:0] bid;

   // Output register
   logic       out_valid_q;
   axis_beat_t out_beat_q;
   logic       out_ready;

   // Output register can load this cycle
   assign out_ready = !out_valid_q || source.ready;

   // --------------------
   // Input stage
   // --------------------

   axis_stream_if sink_in [NUM_CH] ();

   for (genvar c = 0; c < NUM_CH; c++) begin : g_in
      // Skid buffer absorbs stalls without upstream bubbles
      axis_skid_buffer u_skid (
         .clk    (clk),
         .rst_n  (rst_n),
         .sink   (sink[c]),
         .source (sink_in[c])
      );

      assign in_valid[c] = sink_in[c].valid;
      assign in_beat[c]  = sink_in[c].beat;

      // Pop only the granted channel
      assign sink_in[c].ready = sel_1hot[c];
   end

   // --------------------
   // Packet tracking
   // --------------------

   assign hold_any = |hold_1hot;

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CH; i++) begin
         // Set after a middle beat, clear after the last
         if (in_valid[i] && sel_1hot[i]) begin
            hold_1hot[i] <= !in_beat[i].last;
         end
      end
      if (!rst_n) begin
         hold_1hot <= '0;
      end
   end

   // Bid only with room downstream and no other packet in flight
   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         bid[i] = in_valid[i] && (hold_1hot[i] || !hold_any) && out_ready;
      end
   end

   fair_arbiter #(
      .NUM_INPUTS (NUM_CH)
   ) u_arb (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_valid        (bid),
      .hold_priority   (hold_1hot),
      .out_select      (sel),
      .out_select_1hot (sel_1hot),
      .out_valid       (sel_valid)
   );

   // --------------------
   // Output stage
   // --------------------

   // Stalled register keeps its beat, bids are already masked
   always_ff @(posedge clk) begin
      if (out_ready) begin
         out_valid_q <= sel_valid;
         out_beat_q  <= in_beat[sel];
      end
      if (!rst_n) begin
         out_valid_q <= 1'b0;
      end
   end

   assign source.valid = out_valid_q;
   assign source.beat  = out_beat_q;

endmodule

//--- hw/axis_mux_top.sv
// Top level of the stream mux; flat per-channel AXI-Stream ports wrapped onto interfaces
`timescale 1ns/1ps

module axis_mux_top (
   input  logic clk,
   input  logic rst_n,

   // Input channels
   input  logic [axis_mux_pkg::NUM_CH-1:0]                               sink_tvalid,
   output logic [axis_mux_pkg::NUM_CH-1:0]                               sink_tready,
   input  logic [axis_mux_pkg::NUM_CH-1:0][axis_mux_pkg::TDATA_WIDTH-1:0] sink_tdata,
   input  logic [axis_mux_pkg::NUM_CH-1:0][axis_mux_pkg::TKEEP_WIDTH-1:0] sink_tkeep,
   input  logic [axis_mux_pkg::NUM_CH-1:0]                               sink_tlast,
   input  logic [axis_mux_pkg::NUM_CH-1:0][axis_mux_pkg::TUSER_WIDTH-1:0] sink_tuser,

   // Merged output
   output logic                                 source_tvalid,
   input  logic                                 source_tready,
   output logic [axis_mux_pkg::TDATA_WIDTH-1:0] source_tdata,
   output logic [axis_mux_pkg::TKEEP_WIDTH-1:0] source_tkeep,
   output logic                                 source_tlast,
   output logic [axis_mux_pkg::TUSER_WIDTH-1:0] source_tuser
);
   import axis_mux_pkg::*;

   // --------------------
   // Port wrapping
   // --------------------

   axis_stream_if sink_if [NUM_CH] ();
   axis_stream_if source_if ();

   for (genvar c = 0; c < NUM_CH; c++) begin : g_sink
      assign sink_if[c].valid = sink_tvalid[c];
      // Pack flat fields into the beat struct
      assign sink_if[c].beat  = '{
         data: sink_tdata[c],
         keep: sink_tkeep[c],
         last: sink_tlast[c],
         user: sink_tuser[c]
      };
      assign sink_tready[c]   = sink_if[c].ready;
   end

   // Unpack the output beat
   assign source_tvalid   = source_if.valid;
   assign source_tdata    = source_if.beat.data;
   assign source_tkeep    = source_if.beat.keep;
   assign source_tlast    = source_if.beat.last;
   assign source_tuser    = source_if.beat.user;
   assign source_if.ready = source_tready;

   // --------------------
   // Mux core
   // --------------------

   axis_packet_mux #(
      .NUM_CH (NUM_CH)
   ) u_mux (
      .clk    (clk),
      .rst_n  (rst_n),
      .sink   (sink_if),
      .source (source_if)
   );

endmodule

//--- test/axis_mux_tb.sv
// Random-stimulus testbench for the packet mux that runs as the simulation top module
`timescale 1ns/1ps

module axis_mux_tb;
   import axis_mux_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_BEATS    = 6;
   localparam int CNT_WIDTH    = TDATA_WIDTH - SEL_WIDTH - 8;
   localparam int RR_WARMUP    = 4;
   localparam int RR_TARGET    = 60;

   // Generator modes
   localparam int MODE_STOP     = 0;
   localparam int MODE_RANDOM   = 1;
   localparam int MODE_SATURATE = 2;

   logic                               clk;
   logic                               rst_n;
   logic [NUM_CH-1:0]                  sink_tvalid;
   logic [NUM_CH-1:0]                  sink_tready;
   logic [NUM_CH-1:0][TDATA_WIDTH-1:0] sink_tdata;
   logic [NUM_CH-1:0][TKEEP_WIDTH-1:0] sink_tkeep;
   logic [NUM_CH-1:0]                  sink_tlast;
   logic [NUM_CH-1:0][TUSER_WIDTH-1:0] sink_tuser;
   logic                               source_tvalid;
   logic                               source_tready;
   logic [TDATA_WIDTH-1:0]             source_tdata;
   logic [TKEEP_WIDTH-1:0]             source_tkeep;
   logic                               source_tlast;
   logic [TUSER_WIDTH-1:0]             source_tuser;

   // Reference model with one queue of accepted beats per channel
   axis_beat_t  ref_q [NUM_CH][$];
   int          pkt_len [NUM_CH];
   int          beat_idx [NUM_CH];
   int          pkt_cnt [NUM_CH];
   logic [31:0] rng_state;
   int          gen_mode;

   // Output side tracking
   int         beats_sent;
   int         beats_checked;
   int         out_pkts;
   int         rr_checks;
   int         sat_starts;
   int         cur_ch;
   int         last_start_ch;
   logic       in_packet;
   logic       stall_pending;
   axis_beat_t stall_beat;
   logic       rr_enable;

   axis_mux_top u_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .sink_tvalid   (sink_tvalid),
      .sink_tready   (sink_tready),
      .sink_tdata    (sink_tdata),
      .sink_tkeep    (sink_tkeep),
      .sink_tlast    (sink_tlast),
      .sink_tuser    (sink_tuser),
      .source_tvalid (source_tvalid),
      .source_tready (source_tready),
      .source_tdata  (source_tdata),
      .source_tkeep  (source_tkeep),
      .source_tlast  (source_tlast),
      .source_tuser  (source_tuser)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------
   // Helpers
   // --------------------

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Uniform pick in 0 .. n-1
   function automatic int rand_below(input int n);
      rng_state = xorshift(rng_state);
      return int'(rng_state % 32'(n));
   endfunction

   // Channel in the top bits then packet count and beat index in the low byte
   function automatic logic [TDATA_WIDTH-1:0] make_data(input int c, input int cnt,
                                                        input int idx);
      logic [TDATA_WIDTH-1:0] d;
      d = '0;
      d[TDATA_WIDTH-1 -: SEL_WIDTH] = SEL_WIDTH'(c);
      d[TDATA_WIDTH-SEL_WIDTH-1 -: CNT_WIDTH] = CNT_WIDTH'(cnt);
      d[7:0] = 8'(idx);
      return d;
   endfunction

   // Nothing offered, stored or in flight
   function automatic logic all_idle();
      logic idle;
      idle = !source_tvalid && !in_packet;
      for (int c = 0; c < NUM_CH; c++) begin
         if (ref_q[c].size() != 0 || pkt_len[c] != 0 || sink_tvalid[c]) begin
            idle = 1'b0;
         end
      end
      return idle;
   endfunction

   // --------------------
   // Output checks
   // --------------------

   task automatic check_output();
      axis_beat_t got;
      axis_beat_t exp;
      int         ch;
      got = '{data: source_tdata, keep: source_tkeep, last: source_tlast, user: source_tuser};
      // Stalled beat must stay put
      if (stall_pending) begin
         assert (source_tvalid) else stop_on_error("source_tvalid dropped before transfer");
         assert (got == stall_beat) else stop_on_error($sformatf(
            "mismatch backpressure_hold expected %h actual %h", stall_beat, got));
      end
      stall_pending = source_tvalid && !source_tready;
      stall_beat    = got;
      if (source_tvalid && source_tready) begin
         ch = int'(source_tdata[TDATA_WIDTH-1 -: SEL_WIDTH]);
         assert (ref_q[ch].size() > 0) else stop_on_error($sformatf(
            "output beat for channel %0d that was never sent", ch));
         exp = ref_q[ch].pop_front();
         assert (got == exp) else stop_on_error($sformatf(
            "mismatch integrity expected %h actual %h", exp, got));
         if (in_packet) begin
            assert (ch == cur_ch) else stop_on_error($sformatf(
               "mismatch no_interleave expected %0d actual %0d", cur_ch, ch));
         end else begin
            // Packet start with rotation checked once saturation settles
            if (rr_enable) begin
               if (sat_starts >= RR_WARMUP) begin
                  assert (ch == (last_start_ch + 1) % NUM_CH) else stop_on_error($sformatf(
                     "mismatch fairness expected %0d actual %0d",
                     (last_start_ch + 1) % NUM_CH, ch));
                  rr_checks++;
               end
               sat_starts++;
            end
            last_start_ch = ch;
         end
         in_packet = !got.last;
         cur_ch    = ch;
         beats_checked++;
         if (got.last) begin
            out_pkts++;
         end
      end
   endtask

   // --------------------
   // Channel generators
   // --------------------

   task automatic update_channel(input int c);
      axis_beat_t b;
      logic       last;
      if (sink_tvalid[c] && sink_tready[c]) begin
         b = '{data: sink_tdata[c], keep: sink_tkeep[c],
               last: sink_tlast[c], user: sink_tuser[c]};
         ref_q[c].push_back(b);
         beats_sent++;
         beat_idx[c]++;
         if (beat_idx[c] == pkt_len[c]) begin
            beat_idx[c] = 0;
            pkt_len[c]  = 0;
            pkt_cnt[c]++;
         end
      end
      // A waiting beat stays on the bus untouched
      if (!(sink_tvalid[c] && !sink_tready[c])) begin
         if (pkt_len[c] == 0 && (gen_mode == MODE_SATURATE ||
                                 (gen_mode == MODE_RANDOM && rand_below(3) == 0))) begin
            pkt_len[c] = 1 + rand_below(MAX_BEATS);
         end
         if (pkt_len[c] != 0 && (gen_mode == MODE_SATURATE || rand_below(4) != 0)) begin
            last = (beat_idx[c] == pkt_len[c] - 1);
            sink_tvalid[c] <= 1'b1;
            sink_tdata[c]  <= make_data(c, pkt_cnt[c], beat_idx[c]);
            sink_tlast[c]  <= last;
            sink_tkeep[c]  <= last ? TKEEP_WIDTH'(1 + rand_below(2 ** TKEEP_WIDTH - 1)) : '1;
            sink_tuser[c]  <= TUSER_WIDTH'(rand_below(2 ** TUSER_WIDTH));
         end else begin
            sink_tvalid[c] <= 1'b0;
         end
      end
   endtask

   // Monitor then stimulus on every rising edge
   initial begin
      sink_tvalid   <= '0;
      sink_tdata    <= '0;
      sink_tkeep    <= '0;
      sink_tlast    <= '0;
      sink_tuser    <= '0;
      source_tready <= 1'b0;
      rng_state     = 32'ha89a;
      beats_sent    = 0;
      beats_checked = 0;
      out_pkts      = 0;
      rr_checks     = 0;
      sat_starts    = 0;
      cur_ch        = 0;
      last_start_ch = 0;
      in_packet     = 1'b0;
      stall_pending = 1'b0;
      stall_beat    = '0;
      for (int c = 0; c < NUM_CH; c++) begin
         pkt_len[c]  = 0;
         beat_idx[c] = 0;
         pkt_cnt[c]  = 0;
      end
      forever begin
         @(posedge clk);
         if (!rst_n) begin
            sink_tvalid   <= '0;
            source_tready <= 1'b0;
         end else begin
            check_output();
            for (int c = 0; c < NUM_CH; c++) begin
               update_channel(c);
            end
            // Ready three cycles in four
            source_tready <= (rand_below(4) != 0);
         end
      end
   end

   // --------------------
   // Test sequence
   // --------------------

   initial begin
      int cycles;
      rst_n     <= 1'b0;
      gen_mode  <= MODE_STOP;
      rr_enable <= 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
         if (i < RESET_CYCLES - 1) begin
            @(negedge clk);
            assert (source_tvalid === 1'b0) else stop_on_error("source_tvalid high in reset");
         end
      end
      rst_n <= 1'b1;
      @(negedge clk);
      assert (source_tvalid === 1'b0) else stop_on_error("source_tvalid high after reset");
      assert (sink_tready === '1) else stop_on_error($sformatf(
         "mismatch reset_ready expected %b actual %b", {NUM_CH{1'b1}}, sink_tready));

      // Random traffic with random back-pressure
      @(posedge clk);
      gen_mode <= MODE_RANDOM;
      cycles = 0;
      while (out_pkts < 300) begin
         @(negedge clk);
         cycles++;
         assert (cycles < 20000) else stop_on_error("timeout waiting for random-phase packets");
      end

      // Every channel busy with rotation checked after a settle time
      @(posedge clk);
      gen_mode <= MODE_SATURATE;
      for (int i = 0; i < 50; i++) begin
         @(posedge clk);
      end
      rr_enable <= 1'b1;
      cycles = 0;
      while (rr_checks < RR_TARGET) begin
         @(negedge clk);
         cycles++;
         assert (cycles < 5000) else stop_on_error("timeout waiting for saturated packets");
      end

      // Drain until open packets finish and the bus goes quiet
      @(posedge clk);
      rr_enable <= 1'b0;
      gen_mode  <= MODE_STOP;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         assert (cycles < 2000) else stop_on_error("timeout waiting for the mux to drain");
      end while (!all_idle());
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
      end

      // Idle inputs must leave the output quiet
      assert (source_tvalid === 1'b0) else stop_on_error("source_tvalid raised on an idle bus");
      assert (beats_checked == beats_sent && beats_sent > 0) else stop_on_error($sformatf(
         "mismatch beat_count expected %0d actual %0d", beats_sent, beats_checked));
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- list.f
hw/axis_mux_pkg.sv
hw/axis_stream_if.sv
hw/axis_skid_buffer.sv
hw/fair_arbiter.sv
hw/axis_packet_mux.sv
hw/axis_mux_top.sv
test/axis_mux_tb.sv

//--- Makefile
# Verilator flow for the AXI-Stream packet mux

VERILATOR  ?= verilator
FILELIST   ?= list.f
TB_TOP     ?= axis_mux_tb
RTL_TOP    ?= axis_mux_top
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Simulation passed
RTL_SRCS   ?= hw/axis_mux_pkg.sv hw/axis_stream_if.sv hw/axis_skid_buffer.sv \
              hw/fair_arbiter.sv hw/axis_packet_mux.sv hw/axis_mux_top.sv
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
